/* hdl/rv32_pkg.sv */
package rv32_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000; // first fetch address

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load / store access sizes
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    localparam logic [6:0] f7_alt = 7'b0100000; // sub, sra, srai

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none
    } inst_fmt_t;

    // instruction word, one view per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi; // imm[11:5]
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo; // imm[4:0]
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm; // imm[31:12]
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } j;
    } inst_word_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_link,
        wb_none
    } wb_sel_t;

    typedef struct packed {
        inst_fmt_t  fmt;
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        alu_op_t    alu_op;
        wb_sel_t    wb_sel;
        logic       is_load;
        logic       is_store;
        logic       is_jump; // jal or jalr
    } ctrl_t;

    typedef struct packed {
        word_t      addr;  // byte address
        word_t      wdata; // already placed in byte lanes
        logic [3:0] mask;
        logic       we;
    } dmem_req_t;

endpackage

/* hdl/fetch_unit.sv */
module fetch_unit import rv32_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  jump_en,
    input  word_t jump_target,
    output word_t pc,
    output word_t pc_plus4
);

    word_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    // taken branch or jump overrides sequential flow
    assign next_pc = jump_en ? jump_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc; // held for as long as reset stays high
        end else begin
            pc <= next_pc;
        end
    end

endmodule

/* hdl/decode_unit.sv */
module decode_unit import rv32_pkg::*; (
    input  inst_word_u inst,
    output ctrl_t      ctrl
);

    inst_fmt_t fmt;

    // format from the major opcode
    always_comb begin
        unique case (inst.r.opcode)
            op_reg:                    fmt = fmt_r;
            op_imm, op_load, op_jalr:  fmt = fmt_i;
            op_store:                  fmt = fmt_s;
            op_branch:                 fmt = fmt_b;
            op_lui, op_auipc:          fmt = fmt_u;
            op_jal:                    fmt = fmt_j;
            default:                   fmt = fmt_none;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.fmt    = fmt;
        ctrl.opcode = inst.r.opcode;
        ctrl.funct3 = inst.r.funct3;
        ctrl.rd     = inst.r.rd;
        ctrl.rs1    = inst.r.rs1;
        ctrl.rs2    = inst.r.rs2;

        // sign-extended immediate, assembled from the matching view
        unique case (fmt)
            fmt_i: ctrl.imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            fmt_s: ctrl.imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            fmt_b: ctrl.imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            fmt_u: ctrl.imm = {inst.u.imm, 12'b0};
            fmt_j: ctrl.imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default: ctrl.imm = '0;
        endcase

        // alu op, only arithmetic opcodes use funct3 here
        ctrl.alu_op = alu_add;
        if (inst.r.opcode == op_reg || inst.r.opcode == op_imm) begin
            unique case (inst.r.funct3)
                3'b000: ctrl.alu_op = (inst.r.opcode == op_reg && inst.r.funct7 == f7_alt)
                                      ? alu_sub : alu_add; // addi has no sub form
                3'b001: ctrl.alu_op = alu_sll;
                3'b010: ctrl.alu_op = alu_slt;
                3'b011: ctrl.alu_op = alu_sltu;
                3'b100: ctrl.alu_op = alu_xor;
                3'b101: ctrl.alu_op = (inst.r.funct7 == f7_alt) ? alu_sra : alu_srl;
                3'b110: ctrl.alu_op = alu_or;
                default: ctrl.alu_op = alu_and;
            endcase
        end

        // unknown opcode falls to wb_none and no flags, so it behaves as a nop
        unique case (inst.r.opcode)
            op_reg, op_imm, op_lui, op_auipc: ctrl.wb_sel = wb_alu;
            op_load:                          ctrl.wb_sel = wb_load;
            op_jal, op_jalr:                  ctrl.wb_sel = wb_link; // rd gets pc+4
            default:                          ctrl.wb_sel = wb_none;
        endcase

        ctrl.is_load  = (inst.r.opcode == op_load);
        ctrl.is_store = (inst.r.opcode == op_store);
        ctrl.is_jump  = (inst.r.opcode == op_jal) || (inst.r.opcode == op_jalr);
    end

endmodule

/* hdl/reg_file.sv */
module reg_file import rv32_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata; // x0 never written
        end
    end

    // asynchronous reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hdl/execute_unit.sv */
module execute_unit import rv32_pkg::*; (
    input  ctrl_t ctrl,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t pc,
    input  word_t pc_plus4,
    output word_t alu_result,
    output logic  jump_en,
    output word_t jump_target
);

    word_t      alu_a;
    word_t      alu_b;
    logic [4:0] shamt;
    logic       branch_taken;
    word_t      target;

    // operand selection by format
    always_comb begin
        unique case (ctrl.fmt)
            fmt_r: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            fmt_i, fmt_s: begin
                alu_a = rs1_data; // also jalr base and load/store address
                alu_b = ctrl.imm;
            end
            fmt_u: begin
                alu_a = (ctrl.opcode == op_lui) ? '0 : pc;
                alu_b = ctrl.imm;
            end
            fmt_j, fmt_b: begin
                alu_a = pc;
                alu_b = ctrl.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        unique case (ctrl.alu_op)
            alu_sub:  alu_result = alu_a - alu_b;
            alu_sll:  alu_result = alu_a << shamt;
            alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            alu_xor:  alu_result = alu_a ^ alu_b;
            alu_srl:  alu_result = alu_a >> shamt;
            alu_sra:  alu_result = $signed(alu_a) >>> shamt;
            alu_or:   alu_result = alu_a | alu_b;
            alu_and:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // branch compare always on the register operands
    always_comb begin
        branch_taken = 1'b0;
        if (ctrl.fmt == fmt_b) begin
            unique case (ctrl.funct3)
                f3_beq:  branch_taken = (rs1_data == rs2_data);
                f3_bne:  branch_taken = (rs1_data != rs2_data);
                f3_blt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
                f3_bge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
                f3_bltu: branch_taken = (rs1_data < rs2_data);
                f3_bgeu: branch_taken = (rs1_data >= rs2_data);
                default: branch_taken = 1'b0;
            endcase
        end
    end

    always_comb begin
        if (ctrl.opcode == op_jalr) begin
            target = {alu_result[31:1], 1'b0}; // rs1 + imm, lsb cleared
        end else begin
            target = alu_result; // pc + imm for jal and branches
        end
    end

    assign jump_en     = ctrl.is_jump || branch_taken;
    assign jump_target = jump_en ? target : pc_plus4;

endmodule

/* hdl/mem_writeback_unit.sv */
module mem_writeback_unit import rv32_pkg::*; (
    input  logic      reset,
    input  ctrl_t     ctrl,
    input  word_t     alu_result,
    input  word_t     rs2_data,
    input  word_t     pc_plus4,
    input  word_t     dmem_rdata,
    output dmem_req_t dmem_req,
    output logic      rd_we,
    output word_t     rd_wdata
);

    logic [1:0] byte_off;
    logic [4:0] lane_shift;
    logic [3:0] size_mask;
    word_t      load_word;
    word_t      load_data;

    assign byte_off   = alu_result[1:0];
    assign lane_shift = {byte_off, 3'b000}; // byte offset in bits

    always_comb begin
        unique case (ctrl.funct3)
            f3_byte: size_mask = 4'b0001;
            f3_half: size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data << lane_shift;
    assign dmem_req.mask  = size_mask << byte_off;
    assign dmem_req.we    = ctrl.is_store && !reset;

    // addressed byte or halfword moved down to bit 0
    assign load_word = dmem_rdata >> lane_shift;

    always_comb begin
        unique case (ctrl.funct3)
            f3_byte:   load_data = {{24{load_word[7]}}, load_word[7:0]};
            f3_half:   load_data = {{16{load_word[15]}}, load_word[15:0]};
            f3_byte_u: load_data = {24'b0, load_word[7:0]};
            f3_half_u: load_data = {16'b0, load_word[15:0]};
            default:   load_data = load_word; // f3_word
        endcase
    end

    always_comb begin
        unique case (ctrl.wb_sel)
            wb_alu:  rd_wdata = alu_result;
            wb_load: rd_wdata = load_data;
            wb_link: rd_wdata = pc_plus4;
            default: rd_wdata = '0;
        endcase
    end

    assign rd_we = (ctrl.wb_sel != wb_none) && !reset;

endmodule

/* hdl/rv32_core.sv */
module rv32_core import rv32_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_rdata,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    word_t pc;
    word_t pc_plus4;
    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    logic  jump_en;
    word_t jump_target;
    logic  rd_we;
    word_t rd_wdata;

    assign imem_addr = pc; // fetch straight from the pc

    fetch_unit i_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .pc_plus4    (pc_plus4)
    );

    decode_unit i_decode (
        .inst (imem_rdata),
        .ctrl (ctrl)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (rd_we),
        .waddr  (ctrl.rd),
        .wdata  (rd_wdata),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_unit i_execute (
        .ctrl        (ctrl),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .pc_plus4    (pc_plus4),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    mem_writeback_unit i_mem_wb (
        .reset      (reset),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .pc_plus4   (pc_plus4),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .rd_we      (rd_we),
        .rd_wdata   (rd_wdata)
    );

endmodule

/* bench/rv32_single_properties.sv */
module rv32_single_properties import rv32_pkg::*; (
    input logic      clk,
    input logic      reset,
    input word_t     pc,
    input dmem_req_t dmem_req,
    input logic      rd_we
);

    int fail_count = 0;

    // pc sits at the reset vector after any cycle with reset high
    pc_after_reset: assert property (@(posedge clk) reset |=> pc == reset_pc)
        else begin
            fail_count++;
            $error("pc is not at the reset vector after reset");
        end

    we_low_in_reset: assert property (@(posedge clk) reset |-> !dmem_req.we && !rd_we)
        else begin
            fail_count++;
            $error("write enable high during reset");
        end

    // 1, 2 or 4 contiguous bytes, aligned to the access size
    store_mask_legal: assert property (
        @(posedge clk) disable iff (reset)
        dmem_req.we |-> dmem_req.mask inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                              4'b0011, 4'b1100, 4'b1111}
    ) else begin
        fail_count++;
        $error("store mask is not a legal aligned pattern");
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc is not word aligned");
        end

endmodule

bind rv32_core rv32_single_properties i_props (
    .clk      (clk),
    .reset    (reset),
    .pc       (pc),
    .dmem_req (dmem_req),
    .rd_we    (rd_we)
);

/* bench/rv32_single_tb.sv */
module rv32_single_tb import rv32_pkg::*; ();

    typedef struct packed {
        word_t      addr;
        word_t      data;
        logic [3:0] mask;
    } exp_store_t;

    localparam word_t data_base = 32'h0001_0000;
    localparam word_t marker_addr = data_base + 32'h7fc; // stores here must never happen

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_rdata;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t      imem [word_t];
    word_t      dmem [word_t];
    word_t      exp_mem [word_t]; // memory as the program should leave it
    exp_store_t exp_q [$];
    string      name_q [$];
    word_t      gen_pc;
    int         chk_off;
    int         prog_len;
    int         checks_left;
    int         n_checks;
    int         errors;
    int         mem_writes;
    logic       prog_ready;
    word_t      lcg_state;
    exp_store_t cur;
    string      cur_name;
    word_t      lanes;

    rv32_core i_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t bytes_of(logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    // instruction encoders
    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // expected results, straight from the ISA rules
    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return word_t'($signed(a) < $signed(b));
            3'd3: return word_t'(a < b);
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return $signed(a) < $signed(b);
            f3_bge:  return $signed(a) >= $signed(b);
            f3_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t load_model(logic [2:0] f3, word_t addr);
        word_t w;
        w = exp_mem[addr[31:2]] >> (8 * addr[1:0]);
        case (f3)
            f3_byte:   return {{24{w[7]}}, w[7:0]};
            f3_half:   return {{16{w[15]}}, w[15:0]};
            f3_byte_u: return {24'b0, w[7:0]};
            f3_half_u: return {16'b0, w[15:0]};
            default:   return w;
        endcase
    endfunction

    task automatic emit(word_t w);
        imem[gen_pc[31:2]] = w;
        gen_pc += 4;
    endtask

    task automatic load_const(reg_addr_t rd, word_t v);
        word_t hi;
        hi = v + 32'h800; // addi sign-extends the low part
        emit({hi[31:12], rd, op_lui});
        emit(enc_i(v[11:0], rd, 3'b000, rd, op_imm));
    endtask

    task automatic expect_store(string name, word_t addr, word_t data, logic [3:0] mask);
        word_t      m;
        exp_store_t e;
        e.addr = addr;
        e.data = data;
        e.mask = mask;
        exp_q.push_back(e);
        name_q.push_back(name);
        m = bytes_of(mask);
        if (!exp_mem.exists(addr[31:2])) begin
            exp_mem[addr[31:2]] = '0;
        end
        exp_mem[addr[31:2]] = (exp_mem[addr[31:2]] & ~m) | (data & m);
    endtask

    // store a register to the next check slot
    task automatic check_reg(string name, reg_addr_t rs, word_t value);
        emit(enc_s(chk_off[11:0], rs, 5'd2, f3_word));
        expect_store(name, data_base + chk_off, value, 4'hf);
        chk_off += 4;
    endtask

    task automatic marker_store();
        emit(enc_s(12'h7fc, 5'd6, 5'd2, f3_word));
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        word_t x;
        word_t y;
        word_t p;
        logic [11:0] imm;
        logic [2:0] f3;
        logic taken;
        logic [2:0] br_f3 [6];
        logic [2:0] ld_f3 [5];
        br_f3 = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        ld_f3 = '{f3_byte, f3_byte_u, f3_half, f3_half_u, f3_word};
        gen_pc = reset_pc;
        chk_off = 0;
        load_const(5'd2, data_base);
        for (int round = 0; round < 2; round++) begin
            a = next_rand();
            b = next_rand();
            if (round == 1) begin
                a[31] = 1'b1; // mixed signs for the compares
                b[31] = 1'b0;
            end
            load_const(5'd6, a);
            load_const(5'd7, b);
            for (int k = 0; k < 8; k++) begin
                f3 = k[2:0];
                emit(enc_r(7'b0, 5'd7, 5'd6, f3, 5'd8));
                check_reg($sformatf("reg op f3=%0d", k), 5'd8, alu_model(f3, 1'b0, a, b));
                if (k == 0 || k == 5) begin
                    emit(enc_r(f7_alt, 5'd7, 5'd6, f3, 5'd8)); // sub, sra
                    check_reg($sformatf("reg alt f3=%0d", k), 5'd8, alu_model(f3, 1'b1, a, b));
                end
                imm = next_rand() >> 20;
                if (k == 1 || k == 5) begin
                    imm[11:5] = 7'b0;
                end
                emit(enc_i(imm, 5'd6, f3, 5'd8, op_imm));
                check_reg($sformatf("imm op f3=%0d", k), 5'd8,
                          alu_model(f3, 1'b0, a, {{20{imm[11]}}, imm}));
                if (k == 5) begin
                    emit(enc_i({f7_alt, imm[4:0]}, 5'd6, f3, 5'd8, op_imm)); // srai
                    check_reg("srai", 5'd8, alu_model(f3, 1'b1, a, {27'b0, imm[4:0]}));
                end
            end
        end
        x = next_rand();
        emit({x[31:12], 5'd8, op_lui});
        check_reg("lui", 5'd8, {x[31:12], 12'b0});
        p = gen_pc;
        emit({x[31:12], 5'd8, op_auipc});
        check_reg("auipc", 5'd8, p + {x[31:12], 12'b0});
        for (int t = 0; t < 6; t++) begin
            for (int k = 0; k < 2; k++) begin
                a = next_rand() | 32'h8000_0000;
                b = next_rand() & 32'h7fff_ffff;
                if (t < 2) begin
                    x = a;
                    y = (k == 0) ? a : b; // equal, then unequal
                end else begin
                    x = (k == 0) ? a : b;
                    y = (k == 0) ? b : a;
                end
                load_const(5'd6, x);
                load_const(5'd7, y);
                emit(enc_i(12'd0, 5'd0, 3'b000, 5'd5, op_imm));
                taken = branch_model(br_f3[t], x, y);
                emit(enc_b(13'd8, 5'd7, 5'd6, br_f3[t]));
                if (taken) begin
                    marker_store();
                end else begin
                    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, op_imm));
                end
                check_reg($sformatf("branch f3=%0d case %0d", br_f3[t], k), 5'd5,
                          taken ? 32'd0 : 32'd1);
            end
        end
        p = gen_pc;
        emit(enc_j(21'd8, 5'd9));
        marker_store();
        check_reg("jal link", 5'd9, p + 4);
        p = gen_pc + 8; // jalr follows the two-instruction constant load
        load_const(5'd10, p + 8);
        emit(enc_i(12'd1, 5'd10, 3'b000, 5'd11, op_jalr)); // odd target, bit 0 dropped
        marker_store();
        check_reg("jalr link", 5'd11, p + 4);
        a = next_rand() | 32'h8000_8080; // negative low bytes and both halves
        b = next_rand();
        load_const(5'd6, a);
        load_const(5'd7, b);
        emit(enc_s(12'h400, 5'd6, 5'd2, f3_word));
        expect_store("sw", data_base + 32'h400, a, 4'hf);
        for (int k = 0; k < 4; k++) begin
            emit(enc_s(12'h404 + k, 5'd7, 5'd2, f3_byte));
            expect_store($sformatf("sb off %0d", k), data_base + 32'h404 + k,
                         b << (8 * k), 4'b0001 << k);
        end
        for (int k = 0; k < 4; k += 2) begin
            x = (k == 0) ? a : b;
            emit(enc_s(12'h408 + k, (k == 0) ? 5'd6 : 5'd7, 5'd2, f3_half));
            expect_store($sformatf("sh off %0d", k), data_base + 32'h408 + k,
                         x << (8 * k), 4'b0011 << k);
        end
        for (int r = 0; r < 3; r++) begin
            for (int l = 0; l < 5; l++) begin
                for (int off = 0; off < 4; off++) begin
                    if ((l >= 2 && off[0]) || (l == 4 && off != 0)) begin
                        continue; // keep halfword and word loads aligned
                    end
                    p = 32'h400 + 4 * r + off;
                    emit(enc_i(p[11:0], 5'd2, ld_f3[l], 5'd8, op_load));
                    check_reg($sformatf("load f3=%0d addr %h", ld_f3[l], data_base + p), 5'd8,
                              load_model(ld_f3[l], data_base + p));
                end
            end
        end
        emit(enc_i(12'h123, 5'd0, 3'b000, 5'd0, op_imm));
        emit({20'habcde, 5'd0, op_lui});
        check_reg("x0 stays zero", 5'd0, 32'd0);
        emit(enc_j(21'd0, 5'd0)); // park on a self loop
        prog_len = (gen_pc - reset_pc) / 4;
    endtask

    // memory models, combinational reads
    always @(imem_addr or prog_ready) begin
        if ($isunknown(imem_addr) || !imem.exists(imem_addr[31:2])) begin
            imem_rdata = '0;
        end else begin
            imem_rdata = imem[imem_addr[31:2]];
        end
    end

    always @(dmem_req or mem_writes) begin
        if ($isunknown(dmem_req.addr) || !dmem.exists(dmem_req.addr[31:2])) begin
            dmem_rdata = '0;
        end else begin
            dmem_rdata = dmem[dmem_req.addr[31:2]];
        end
    end

    // write port plus store monitor
    always @(posedge clk) begin
        if (!reset && dmem_req.we) begin
            lanes = bytes_of(dmem_req.mask);
            if (!dmem.exists(dmem_req.addr[31:2])) begin
                dmem[dmem_req.addr[31:2]] = '0;
            end
            dmem[dmem_req.addr[31:2]] = (dmem[dmem_req.addr[31:2]] & ~lanes)
                                        | (dmem_req.wdata & lanes);
            mem_writes++;
            if (dmem_req.addr == marker_addr) begin
                errors++;
                $display("store in a skipped slot was executed, pc %h", imem_addr);
            end else if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected store to address %h", dmem_req.addr);
            end else begin
                cur = exp_q.pop_front();
                cur_name = name_q.pop_front();
                lanes = bytes_of(cur.mask);
                assert (dmem_req.addr == cur.addr) else begin
                    errors++;
                    $display("FAIL %s addr: expected %h actual %h", cur_name, cur.addr,
                             dmem_req.addr);
                end
                assert (dmem_req.mask == cur.mask) else begin
                    errors++;
                    $display("FAIL %s mask: expected %h actual %h", cur_name, cur.mask,
                             dmem_req.mask);
                end
                assert ((dmem_req.wdata & lanes) == (cur.data & lanes)) else begin
                    errors++;
                    $display("FAIL %s data: expected %h actual %h", cur_name,
                             cur.data & lanes, dmem_req.wdata & lanes);
                end
                checks_left--;
            end
        end
    end

    initial begin
        wait (prog_ready);
        #((prog_len + 50 + 8) * 100);
        $display("timeout, %0d of %0d stores never arrived", checks_left, n_checks);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        errors = 0;
        mem_writes = 0;
        prog_ready = 1'b0;
        lcg_state = 32'd10;
        build_program();
        n_checks = exp_q.size();
        checks_left = n_checks;
        prog_ready = 1'b1;
        repeat (8) @(posedge clk);
        #10 reset = 1'b0;
        wait (checks_left == 0);
        repeat (2) @(posedge clk);
        $display("errors: %0d, property failures: %0d, store checks: %0d", errors,
                 i_dut.i_props.fail_count, n_checks);
        if (errors == 0 && i_dut.i_props.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* rv32_single.f */
hdl/rv32_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/mem_writeback_unit.sv
hdl/rv32_core.sv
bench/rv32_single_properties.sv
bench/rv32_single_tb.sv

/* Bender.yml */
package:
  name: rv32_single

sources:
  - hdl/rv32_pkg.sv
  - hdl/fetch_unit.sv
  - hdl/decode_unit.sv
  - hdl/reg_file.sv
  - hdl/execute_unit.sv
  - hdl/mem_writeback_unit.sv
  - hdl/rv32_core.sv
  - target: test
    files:
      - bench/rv32_single_properties.sv
      - bench/rv32_single_tb.sv
